// File: source/ldpc_dec_params.svh
// LDPC decoder LLR path code parameters
// QC code with a 2x4 base matrix and circulant size 8, 6-bit LLRs

`ifndef LDPC_DEC_PARAMS_SVH
`define LDPC_DEC_PARAMS_SVH

// --------------------
// code geometry
// --------------------

`define LDPC_Z      8   // circulant size, power of two
`define LDPC_C      2   // block rows of the base matrix
`define LDPC_T      4   // block columns, one LLR bank each

// --------------------
// datapath
// --------------------

`define LDPC_LLR_W  6   // signed channel LLR

`endif

// File: source/ldpc_types_pkg.sv
// LDPC LLR path types
// width typedefs, FSM/command enums and datapath structs

`default_nettype none

`include "ldpc_dec_params.svh"

package ldpc_types_pkg;

  localparam int ZCNT_W = $clog2(`LDPC_Z);  // row in circulant == bank address
  localparam int TCNT_W = $clog2(`LDPC_T);
  localparam int CCNT_W = $clog2(`LDPC_C);

  typedef logic signed [`LDPC_LLR_W-1:0] llr_t;
  typedef logic [ZCNT_W-1:0] zcnt_t;
  typedef logic [TCNT_W-1:0] tcnt_t;       // block column
  typedef logic [CCNT_W-1:0] ccnt_t;       // block row
  typedef logic [ZCNT_W-1:0] shift_t;      // circulant shift

  typedef enum logic [1:0] {CMD_LOAD, CMD_READ_VNODE, CMD_READ_CNODE} cmd_e;

  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_READ, ST_DRAIN} seq_state_e;

  // --------------------
  // datapath structs
  // --------------------

  typedef struct packed {
    logic  en;
    tcnt_t bank;
    zcnt_t addr;
    llr_t  data;
  } wr_req_s;

  typedef struct packed {
    logic                     valid;
    logic                     cnode;  // permuted pass
    zcnt_t [`LDPC_T-1:0]      addr;   // one address per bank
    ccnt_t                    ccnt;
    zcnt_t                    zcnt;
    logic                     last;
  } rd_req_s;

  typedef struct packed {
    llr_t [`LDPC_T-1:0] lane;  // lane t from bank t
    ccnt_t              ccnt;
    zcnt_t              zcnt;
    logic               last;
  } rd_word_s;

endpackage

`default_nettype wire

// File: source/ldpc_code_pkg.sv
// LDPC base matrix shift table
// circulant shift per block row and block column

`default_nettype none

`include "ldpc_dec_params.svh"

package ldpc_code_pkg;

  import ldpc_types_pkg::*;

  // --------------------
  // base matrix
  // --------------------

  // no null circulants in this code, every entry is a real shift
  localparam shift_t SHIFT_TAB [`LDPC_C][`LDPC_T] = '{
    '{3'd0, 3'd3, 3'd5, 3'd7},  // row 0
    '{3'd2, 3'd6, 3'd1, 3'd4}   // row 1
  };

  // --------------------
  // lookup
  // --------------------

  function automatic shift_t get_shift(input ccnt_t c, input tcnt_t t);
    return SHIFT_TAB[c][t];
  endfunction

endpackage

`default_nettype wire

// File: source/ldpc_load_ctrl.sv
// LDPC LLR load controller
// takes the channel LLR stream column-major, writes banks linearly

`default_nettype none

`include "ldpc_dec_params.svh"

module ldpc_load_ctrl import ldpc_types_pkg::*; (
  input  logic    iclk,
  input  logic    rst,
  input  logic    load_start,  // arm for one codeword
  input  logic    in_valid,
  input  llr_t    in_llr,
  output logic    in_ready,
  output wr_req_s wr_req,      // registered bank write
  output logic    load_done    // with the last write
);

  logic armed;
  logic accept;
  logic last_beat;

  struct packed {
    zcnt_t val;
    logic  done;
  } zcnt;   // inner, row in circulant

  struct packed {
    tcnt_t val;
    logic  done;
  } tcnt;   // outer, bank

  assign in_ready  = armed;
  assign accept    = in_valid & armed;
  assign last_beat = zcnt.done & tcnt.done;

  always_ff @(posedge iclk) begin
    if (rst) begin
      armed     <= 1'b0;
      zcnt      <= '{val: '0, done: (`LDPC_Z == 1)};
      tcnt      <= '{val: '0, done: (`LDPC_T == 1)};
      wr_req.en <= 1'b0;
      load_done <= 1'b0;
    end else begin
      wr_req.en <= accept;
      load_done <= accept & last_beat;
      if (accept) begin
        wr_req.bank <= tcnt.val;
        wr_req.addr <= zcnt.val;
        wr_req.data <= in_llr;
      end
      // counters, done flags one step ahead
      if (load_start) begin
        armed <= 1'b1;
        zcnt  <= '{val: '0, done: (`LDPC_Z == 1)};
        tcnt  <= '{val: '0, done: (`LDPC_T == 1)};
      end else if (accept) begin
        if (last_beat) begin
          armed <= 1'b0;  // codeword complete
          zcnt  <= '{val: '0, done: (`LDPC_Z == 1)};
          tcnt  <= '{val: '0, done: (`LDPC_T == 1)};
        end else if (zcnt.done) begin
          zcnt      <= '{val: '0, done: (`LDPC_Z == 1)};
          tcnt.val  <= tcnt.val + 1'b1;
          tcnt.done <= (tcnt.val == tcnt_t'(`LDPC_T-2));
        end else begin
          zcnt.val  <= zcnt.val + 1'b1;
          zcnt.done <= (zcnt.val == zcnt_t'(`LDPC_Z-2));
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ldpc_addr_gen.sv
// LDPC LLR read address generator
// stage 1: schedule + shift lookup, stage 2: modulo Z reduce
// vnode = linear, cnode = per-bank shifted address

`default_nettype none

`include "ldpc_dec_params.svh"

module ldpc_addr_gen
  import ldpc_types_pkg::*;
  import ldpc_code_pkg::*;
(
  input  logic    iclk,
  input  logic    rst,
  input  logic    rd_start,       // one-cycle pass start
  input  logic    cnode,          // held for the whole pass
  input  logic    adv,            // pipeline clock enable
  output rd_req_s rd_req,
  output logic    rd_issue_done   // last request of the pass issued
);

  typedef logic [ZCNT_W:0] sum_t;  // one extra bit before modulo

  logic active;
  logic issue;
  logic last;

  struct packed {
    zcnt_t val;
    logic  done;
  } zcnt;

  struct packed {
    ccnt_t val;
    logic  done;
  } ccnt;   // cnode only

  struct packed {
    logic               valid;
    logic               cnode;
    sum_t [`LDPC_T-1:0] sum;
    ccnt_t              ccnt;
    zcnt_t              zcnt;
    logic               last;
  } s1;

  assign issue         = adv & (active | rd_start);
  assign last          = zcnt.done & (~cnode | ccnt.done);
  assign rd_issue_done = issue & last;

  // --------------------
  // schedule counters
  // --------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      active <= 1'b0;
      zcnt   <= '{val: '0, done: (`LDPC_Z == 1)};
      ccnt   <= '{val: '0, done: (`LDPC_C == 1)};
    end else begin
      if (rd_start) active <= 1'b1;  // holds over a stall
      if (issue) begin
        if (last) begin
          active <= 1'b0;
          zcnt   <= '{val: '0, done: (`LDPC_Z == 1)};
          ccnt   <= '{val: '0, done: (`LDPC_C == 1)};
        end else if (zcnt.done) begin
          // next block row, cnode only
          zcnt      <= '{val: '0, done: (`LDPC_Z == 1)};
          ccnt.val  <= ccnt.val + 1'b1;
          ccnt.done <= (ccnt.val == ccnt_t'(`LDPC_C-2));
        end else begin
          zcnt.val  <= zcnt.val + 1'b1;
          zcnt.done <= (zcnt.val == zcnt_t'(`LDPC_Z-2));
        end
      end
    end
  end

  // stage 1 -- table lookup and add
  always_ff @(posedge iclk) begin
    if (rst) begin
      s1.valid <= 1'b0;
    end else if (adv) begin
      s1.valid <= issue;
      s1.cnode <= cnode;
      s1.ccnt  <= ccnt.val;
      s1.zcnt  <= zcnt.val;
      s1.last  <= last;
      for (int t = 0; t < `LDPC_T; t++) begin
        s1.sum[t] <= {1'b0, zcnt.val} +
                     (cnode ? {1'b0, get_shift(ccnt.val, tcnt_t'(t))} : '0);
      end
    end
  end

  // stage 2 -- modulo Z
  always_ff @(posedge iclk) begin
    if (rst) begin
      rd_req.valid <= 1'b0;
    end else if (adv) begin
      rd_req.valid <= s1.valid;
      rd_req.cnode <= s1.cnode;
      rd_req.ccnt  <= s1.ccnt;
      rd_req.zcnt  <= s1.zcnt;
      rd_req.last  <= s1.last;
      for (int t = 0; t < `LDPC_T; t++) begin
        rd_req.addr[t] <= get_mod(s1.sum[t]);
      end
    end
  end

  // subtract Z, keep the sum if it borrowed
  function automatic zcnt_t get_mod(input sum_t sum);
    sum_t diff;
    diff = sum - sum_t'(`LDPC_Z);
    return diff[ZCNT_W] ? sum[ZCNT_W-1:0] : diff[ZCNT_W-1:0];
  endfunction

endmodule

`default_nettype wire

// File: source/ldpc_llr_mem.sv
// LDPC LLR banked memory
// one bank per block column, registered read held on stall

`default_nettype none

`include "ldpc_dec_params.svh"

module ldpc_llr_mem import ldpc_types_pkg::*; (
  input  logic     iclk,
  input  logic     rst,
  input  logic     adv,       // read stage enable
  input  wr_req_s  wr_req,
  input  rd_req_s  rd_req,
  output rd_word_s rd_word,
  output logic     rd_valid
);

  llr_t mem_q [`LDPC_T][`LDPC_Z];  // [bank][row]

  // --------------------
  // write port
  // --------------------

  always_ff @(posedge iclk) begin
    for (int t = 0; t < `LDPC_T; t++) begin
      if (wr_req.en && (wr_req.bank == tcnt_t'(t))) begin
        mem_q[t][wr_req.addr] <= wr_req.data;
      end
    end
  end

  // --------------------
  // read port
  // --------------------

  always_ff @(posedge iclk) begin
    if (rst) rd_valid <= 1'b0;
    else if (adv) rd_valid <= rd_req.valid;
  end

  always_ff @(posedge iclk) begin
    if (adv) begin
      for (int t = 0; t < `LDPC_T; t++) begin
        rd_word.lane[t] <= mem_q[t][rd_req.addr[t]];  // own address per bank
      end
      rd_word.ccnt <= rd_req.ccnt;
      rd_word.zcnt <= rd_req.zcnt;
      rd_word.last <= rd_req.last;
    end
  end

endmodule

`default_nettype wire

// File: source/ldpc_seq_ctrl.sv
// LDPC LLR path sequencer
// command FSM, read mode latch, pipeline advance from output handshake

`default_nettype none

module ldpc_seq_ctrl import ldpc_types_pkg::*; (
  input  logic iclk,
  input  logic rst,
  input  logic cmd_valid,
  input  cmd_e cmd,
  input  logic load_done,
  input  logic rd_issue_done,
  input  logic rd_valid,       // output word present
  input  logic out_ready,
  input  logic last_out,       // last tag of the output word
  output logic cmd_ready,
  output logic load_start,
  output logic rd_start,
  output logic cnode,          // latched read mode
  output logic adv
);

  seq_state_e state;
  logic       cmd_fire;
  logic       out_fire;

  assign cmd_ready = (state == ST_IDLE);
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign out_fire  = rd_valid & out_ready;
  assign adv       = ~rd_valid | out_ready;  // stall on held word

  // --------------------
  // command FSM
  // --------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      state      <= ST_IDLE;
      load_start <= 1'b0;
      rd_start   <= 1'b0;
      cnode      <= 1'b0;
    end else begin
      load_start <= 1'b0;  // pulses
      rd_start   <= 1'b0;
      unique case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            case (cmd)
              CMD_LOAD: begin
                state      <= ST_LOAD;
                load_start <= 1'b1;
              end
              CMD_READ_VNODE, CMD_READ_CNODE: begin
                state    <= ST_READ;
                rd_start <= 1'b1;
                cnode    <= (cmd == CMD_READ_CNODE);
              end
              default: state <= ST_IDLE;  // unknown command dropped
            endcase
          end
        end
        ST_LOAD: begin
          if (load_done) state <= ST_IDLE;
        end
        ST_READ: begin
          if (rd_issue_done) state <= ST_DRAIN;  // requests all issued
        end
        ST_DRAIN: begin
          if (out_fire && last_out) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/ldpc_llr_shuffle_top.sv
// LDPC LLR memory path top
// load stream into banks, read back in vnode or cnode order

`default_nettype none

module ldpc_llr_shuffle_top import ldpc_types_pkg::*; (
  input  logic     iclk,
  input  logic     rst,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  cmd_e     cmd,
  input  logic     in_valid,
  output logic     in_ready,
  input  llr_t     in_llr,
  output logic     out_valid,
  input  logic     out_ready,
  output rd_word_s out_word
);

  logic    load_start;
  logic    load_done;
  logic    rd_start;
  logic    cnode;
  logic    adv;
  logic    rd_issue_done;
  wr_req_s wr_req;
  rd_req_s rd_req;

  ldpc_seq_ctrl u_seq_ctrl (
    .iclk(iclk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd(cmd),
    .load_done(load_done), .rd_issue_done(rd_issue_done),
    .rd_valid(out_valid), .out_ready(out_ready), .last_out(out_word.last),
    .cmd_ready(cmd_ready), .load_start(load_start),
    .rd_start(rd_start), .cnode(cnode), .adv(adv)
  );

  ldpc_load_ctrl u_load_ctrl (
    .iclk(iclk), .rst(rst),
    .load_start(load_start), .in_valid(in_valid), .in_llr(in_llr),
    .in_ready(in_ready), .wr_req(wr_req), .load_done(load_done)
  );

  ldpc_addr_gen u_addr_gen (
    .iclk(iclk), .rst(rst),
    .rd_start(rd_start), .cnode(cnode), .adv(adv),
    .rd_req(rd_req), .rd_issue_done(rd_issue_done)
  );

  // memory read stage is the output register
  ldpc_llr_mem u_llr_mem (
    .iclk(iclk), .rst(rst), .adv(adv),
    .wr_req(wr_req), .rd_req(rd_req),
    .rd_word(out_word), .rd_valid(out_valid)
  );

endmodule

`default_nettype wire

// File: dv/ldpc_llr_shuffle_properties.sv
// LDPC LLR path handshake assertions
// bound into the top level

`default_nettype none

module ldpc_llr_shuffle_properties import ldpc_types_pkg::*; (
  input logic     iclk,
  input logic     rst,
  input logic     cmd_ready,
  input logic     in_ready,
  input logic     out_valid,
  input logic     out_ready,
  input rd_word_s out_word
);

  // --------------------
  // output stream
  // --------------------

  // held word stays put until taken
  a_out_stable: assert property (@(posedge iclk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else $error("out_word changed while stalled");

  // load and read never overlap
  a_in_out_excl: assert property (@(posedge iclk) disable iff (rst)
    !(in_ready && out_valid))
    else $error("in_ready and out_valid both high");

  a_busy_on_out: assert property (@(posedge iclk) disable iff (rst)
    out_valid |-> !cmd_ready)   // no command while words pending
    else $error("cmd_ready high with out_valid");

endmodule

bind ldpc_llr_shuffle_top ldpc_llr_shuffle_properties u_props (
  .iclk(iclk), .rst(rst), .cmd_ready(cmd_ready), .in_ready(in_ready),
  .out_valid(out_valid), .out_ready(out_ready), .out_word(out_word)
);

`default_nettype wire

// File: dv/ldpc_llr_shuffle_tb.sv
// LDPC LLR path testbench
// table of load and read cases against a reference model
// random stalls on out_ready

`default_nettype none

`include "ldpc_dec_params.svh"

module ldpc_llr_shuffle_tb
  import ldpc_types_pkg::*;
  import ldpc_code_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int N_CASES         = 8;
  localparam int WATCHDOG_CYCLES = N_CASES * 64 * 4;  // x4 for stalls

  typedef struct {
    bit   reload;     // load fresh data first
    cmd_e cmd;
    int   stall_pct;  // chance of out_ready low
    int   n_words;
  } case_t;

  case_t    cases [N_CASES];
  logic     iclk;
  logic     rst;
  logic     cmd_valid;
  logic     cmd_ready;
  cmd_e     cmd;
  logic     in_valid;
  logic     in_ready;
  llr_t     in_llr;
  logic     out_valid;
  logic     out_ready;
  rd_word_s out_word;
  llr_t     model [`LDPC_T][`LDPC_Z];  // [column][row] of the last loaded codeword
  int       n_checks;
  int       n_errors;

  ldpc_llr_shuffle_top uut (
    .iclk(iclk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
    .in_valid(in_valid), .in_ready(in_ready), .in_llr(in_llr),
    .out_valid(out_valid), .out_ready(out_ready), .out_word(out_word)
  );

  initial begin
    iclk = 1'b0;
    forever #(CLK_PERIOD/2) iclk = ~iclk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, run not complete after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------
  // helpers
  // --------------------

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // lane t from column t, cnode order adds the block shift mod Z
  function automatic rd_word_s expected_word(input bit cn, input int idx);
    rd_word_s w;
    int       c;
    int       z;
    int       n;
    int       row;
    c = cn ? idx / `LDPC_Z : 0;
    z = idx % `LDPC_Z;
    n = cn ? `LDPC_C * `LDPC_Z : `LDPC_Z;
    for (int t = 0; t < `LDPC_T; t++) begin
      row = cn ? (z + int'(get_shift(ccnt_t'(c), tcnt_t'(t)))) % `LDPC_Z : z;
      w.lane[t] = model[t][row];
    end
    w.ccnt = ccnt_t'(c);
    w.zcnt = zcnt_t'(z);
    w.last = (idx == n - 1);
    return w;
  endfunction

  task automatic send_command(input cmd_e c);
    @(negedge iclk);
    cmd_valid = 1'b1;
    cmd       = c;
    while (!cmd_ready) @(negedge iclk);
    @(posedge iclk);  // handshake edge
  endtask

  // column-major stream with t outer and z inner
  task automatic load_codeword();
    send_command(CMD_LOAD);
    for (int t = 0; t < `LDPC_T; t++) begin
      for (int z = 0; z < `LDPC_Z; z++) begin
        @(negedge iclk);
        cmd_valid   = 1'b0;
        model[t][z] = llr_t'($urandom());
        in_valid    = 1'b1;
        in_llr      = model[t][z];
        check_value("cmd_ready during load", cmd_ready, 0);
        while (!in_ready) begin
          @(negedge iclk);
          check_value("cmd_ready during load", cmd_ready, 0);
        end
        @(posedge iclk);  // beat taken
      end
    end
    @(negedge iclk);
    in_valid = 1'b0;
    check_value("cmd_ready during load", cmd_ready, 0);  // last write still pending
  endtask

  task automatic read_pass(input cmd_e c, input int stall_pct, input int n_words);
    int idx;
    int n_cyc;
    bit seen;
    bit cn;
    cn    = (c == CMD_READ_CNODE);
    idx   = 0;
    n_cyc = 0;  // clock edges since the handshake edge
    seen  = 1'b0;
    send_command(c);
    while (idx < n_words) begin
      @(negedge iclk);
      cmd_valid = 1'b0;
      out_ready = ($urandom_range(99) >= stall_pct);
      check_value("cmd_ready during read", cmd_ready, 0);
      if (out_valid && !seen) begin
        seen = 1'b1;
        check_value("first out_valid latency", n_cyc, 3);  // lookup, mod, bank read
      end
      if (out_valid && out_ready) begin
        check_value($sformatf("word %0d", idx), out_word, expected_word(cn, idx));
        idx++;
      end
      n_cyc++;
    end
    @(negedge iclk);
    out_ready = 1'b0;
    check_value("out_valid after last word", out_valid, 0);  // no extra word
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(32'h7630_8079));
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = CMD_LOAD;
    in_valid  = 1'b0;
    in_llr    = '0;
    out_ready = 1'b0;
    n_checks  = 0;
    n_errors  = 0;

    cases[0] = '{1'b1, CMD_READ_VNODE, 0, 8};
    cases[1] = '{1'b0, CMD_READ_CNODE, 0, 16};
    cases[2] = '{1'b0, CMD_READ_VNODE, 50, 8};
    cases[3] = '{1'b0, CMD_READ_CNODE, 60, 16};
    cases[4] = '{1'b1, CMD_READ_CNODE, 0, 16};   // new data
    cases[5] = '{1'b0, CMD_READ_VNODE, 40, 8};
    cases[6] = '{1'b1, CMD_READ_VNODE, 70, 8};
    cases[7] = '{1'b0, CMD_READ_CNODE, 30, 16};

    repeat (2) @(posedge iclk);
    @(negedge iclk);
    rst = 1'b0;
    check_value("in_ready after reset", in_ready, 0);
    check_value("out_valid after reset", out_valid, 0);
    check_value("cmd_ready after reset", cmd_ready, 1);

    for (int i = 0; i < N_CASES; i++) begin
      if (cases[i].reload) load_codeword();
      read_pass(cases[i].cmd, cases[i].stall_pct, cases[i].n_words);
    end

    repeat (2) @(negedge iclk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/ldpc_types_pkg.sv
source/ldpc_code_pkg.sv
source/ldpc_load_ctrl.sv
source/ldpc_addr_gen.sv
source/ldpc_llr_mem.sv
source/ldpc_seq_ctrl.sv
source/ldpc_llr_shuffle_top.sv
dv/ldpc_llr_shuffle_properties.sv
dv/ldpc_llr_shuffle_tb.sv

// File: run.sh
#!/bin/sh
# build and run the LDPC LLR path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module ldpc_llr_shuffle_tb -o ldpc_sim

# a failed assertion can stop the simulator early, the search below decides
out=$(./obj_dir/ldpc_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
